// File: verilog.f
source/hyperx_pkg.sv
source/update_fifo.sv
source/rotating_arbiter.sv
source/dimension_switch.sv
source/router_node.sv
source/hyperx_network.sv
test/tb_hyperx_network.sv

// File: Bender.yml
package:
  name: hyperx_network

sources:
  - source/hyperx_pkg.sv
  - source/update_fifo.sv
  - source/rotating_arbiter.sv
  - source/dimension_switch.sv
  - source/router_node.sv
  - source/hyperx_network.sv
  - target: test
    files:
      - test/tb_hyperx_network.sv

// File: test/tb_hyperx_network.sv
`timescale 1ns/1ns

module tb_hyperx_network;
    import hyperx_pkg::*;

    localparam int PAIRS          = CORE_NUM * CORE_NUM;
    localparam int SB_DEPTH       = 1024;
    localparam int RANDOM_PER_SRC = 250;
    localparam int BP_CORE        = 5;
    localparam int BP_CYCLES      = 200;

    // Rough length of each test in cycles
    localparam int RESET_LEN   = 10;
    localparam int SINGLE_LEN  = 100;
    localparam int RANDOM_LEN  = 1500;
    localparam int BP_LEN      = 600;
    localparam int END_LEN     = 100;
    localparam int CYCLE_LIMIT = 4 * (RESET_LEN + SINGLE_LEN + RANDOM_LEN + BP_LEN + END_LEN);

    logic                                clk;
    logic                                rst;
    core_vec_t                           in_valid;
    v_id_t      [CORE_NUM-1:0]           in_v_id;
    v_value_t   [CORE_NUM-1:0]           in_v_value;
    core_vec_t                           in_iteration_end;
    iteration_t [CORE_NUM-1:0]           in_iteration_id;
    core_vec_t                           core_full;
    core_vec_t                           stage_full;
    core_vec_t                           out_valid;
    v_id_t      [CORE_NUM-1:0]           out_v_id;
    v_value_t   [CORE_NUM-1:0]           out_v_value;
    core_vec_t                           iteration_end;
    iteration_t [CORE_NUM-1:0]           iteration_id;

    // Expected words per source/destination pair in send order
    v_id_t    exp_id  [PAIRS][SB_DEPTH];
    v_value_t exp_val [PAIRS][SB_DEPTH];
    int       sent_cnt [PAIRS];
    int       recv_cnt [PAIRS];

    integer seed;
    int     serial;
    int     error_count;
    int     test_base;
    int     test_count;
    int     cycle_cnt;

    hyperx_network u_dut (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (in_valid),
        .in_v_id          (in_v_id),
        .in_v_value       (in_v_value),
        .in_iteration_end (in_iteration_end),
        .in_iteration_id  (in_iteration_id),
        .core_full        (core_full),
        .stage_full       (stage_full),
        .out_valid        (out_valid),
        .out_v_id         (out_v_id),
        .out_v_value      (out_v_value),
        .iteration_end    (iteration_end),
        .iteration_id     (iteration_id)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference and scoreboard
    ////////////////////////////////////////////////////////////////////////////

    // Owner core is y * COL_NUM + x with x in the low id bits
    function automatic int dest_core(input v_id_t id);
        int x;
        int y;
        x = int'(id[COL_ID_WIDTH-1:0]);
        y = int'(id[COL_ID_WIDTH +: ROW_ID_WIDTH]);
        return y * COL_NUM + x;
    endfunction

    function automatic logic all_drained();
        logic done;
        done = 1'b1;
        for (int p = 0; p < PAIRS; p++) begin
            if (recv_cnt[p] != sent_cnt[p]) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic next_cycle();
        @(negedge clk);
        in_valid = '0;
    endtask

    // Source number in the top value byte keeps every update unique
    task automatic push_update(input int src, input int dest);
        int       pair;
        int       idx;
        v_id_t    id;
        v_value_t value;
        id = v_id_t'($random(seed));
        id[COL_ID_WIDTH-1:0] = COL_ID_WIDTH'(dest % COL_NUM);
        id[COL_ID_WIDTH +: ROW_ID_WIDTH] = ROW_ID_WIDTH'(dest / COL_NUM);
        value = {8'(src), 24'(serial)};
        serial++;
        pair = src * CORE_NUM + dest;
        idx = sent_cnt[pair] % SB_DEPTH;
        exp_id[pair][idx] = id;
        exp_val[pair][idx] = value;
        sent_cnt[pair]++;
        in_valid[src] = 1'b1;
        in_v_id[src] = id;
        in_v_value[src] = value;
    endtask

    task automatic check_delivery(input int d);
        int src;
        int pair;
        int idx;
        src = int'(out_v_value[d][V_VALUE_WIDTH-1 -: 8]);
        if (dest_core(out_v_id[d]) != d) begin
            $display("[ERROR] out_v_id[%0d]: got 0x%h, owner is core %0d",
                d, out_v_id[d], dest_core(out_v_id[d]));
            error_count++;
        end else if (src >= CORE_NUM) begin
            $display("Core %0d received an update with unknown source %0d", d, src);
            error_count++;
        end else begin
            pair = src * CORE_NUM + d;
            idx = recv_cnt[pair] % SB_DEPTH;
            if (recv_cnt[pair] == sent_cnt[pair]) begin
                $display("Core %0d received an update from core %0d that was never sent",
                    d, src);
                error_count++;
            end else begin
                if (out_v_id[d] !== exp_id[pair][idx]) begin
                    $display("[ERROR] out_v_id[%0d]: expected 0x%h, got 0x%h",
                        d, exp_id[pair][idx], out_v_id[d]);
                    error_count++;
                end
                if (out_v_value[d] !== exp_val[pair][idx]) begin
                    $display("[ERROR] out_v_value[%0d]: expected 0x%h, got 0x%h",
                        d, exp_val[pair][idx], out_v_value[d]);
                    error_count++;
                end
                recv_cnt[pair]++;
            end
        end
    endtask

    task automatic wait_drain();
        while (!all_drained()) begin
            next_cycle();
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, error_count - test_base);
        test_base = error_count;
        test_count++;
    endtask

    // Every core sends per_src updates to random owners
    task automatic run_random(input int per_src);
        int left [CORE_NUM];
        int busy;
        for (int s = 0; s < CORE_NUM; s++) begin
            left[s] = per_src;
        end
        busy = 1;
        while (busy != 0) begin
            next_cycle();
            busy = 0;
            for (int s = 0; s < CORE_NUM; s++) begin
                if (left[s] > 0 && !stage_full[s] && ($random(seed) & 3) != 0) begin
                    push_update(s, $random(seed) & (CORE_NUM - 1));
                    left[s]--;
                end
                busy += left[s];
            end
        end
        next_cycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output compare and run limit
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            for (int d = 0; d < CORE_NUM; d++) begin
                if (out_valid[d]) begin
                    check_delivery(d);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic stage_seen;
        logic dropped;
        int   wait_cnt;
        clk = 1'b0;
        rst = 1'b1;
        in_valid = '0;
        in_v_id = '0;
        in_v_value = '0;
        in_iteration_end = '0;
        in_iteration_id = '0;
        core_full = '0;
        seed = 32'h1862;
        serial = 0;
        error_count = 0;
        test_base = 0;
        test_count = 0;
        cycle_cnt = 0;
        for (int p = 0; p < PAIRS; p++) begin
            sent_cnt[p] = 0;
            recv_cnt[p] = 0;
        end
        repeat (4) @(negedge clk);

        // Outputs right after the last reset edge
        if (out_valid !== '0) begin
            $display("[ERROR] out_valid: expected 0x00, got 0x%h", out_valid);
            error_count++;
        end
        if (iteration_end !== '0) begin
            $display("[ERROR] iteration_end: expected 0x00, got 0x%h", iteration_end);
            error_count++;
        end
        if (stage_full !== '0) begin
            $display("[ERROR] stage_full: expected 0x00, got 0x%h", stage_full);
            error_count++;
        end
        end_test("Reset state");
        rst = 1'b0;

        // One update from every core to every owner
        for (int d = 0; d < CORE_NUM; d++) begin
            next_cycle();
            for (int s = 0; s < CORE_NUM; s++) begin
                push_update(s, (s + d) % CORE_NUM);
            end
        end
        next_cycle();
        wait_drain();
        end_test("Single updates");

        run_random(RANDOM_PER_SRC);
        wait_drain();
        end_test("Random traffic");

        // All sources aim at one stalled core
        stage_seen = 1'b0;
        next_cycle();
        core_full[BP_CORE] = 1'b1;
        for (int c = 0; c < BP_CYCLES; c++) begin
            next_cycle();
            if (out_valid[BP_CORE] !== 1'b0) begin
                $display("[ERROR] out_valid[%0d]: expected 0x0, got 0x%h",
                    BP_CORE, out_valid[BP_CORE]);
                error_count++;
            end
            if (stage_full != '0) begin
                stage_seen = 1'b1;
            end
            for (int s = 0; s < CORE_NUM; s++) begin
                if (!stage_full[s]) begin
                    push_update(s, BP_CORE);
                end
            end
        end
        next_cycle();
        core_full[BP_CORE] = 1'b0;
        if (!stage_seen) begin
            $display("stage_full never rose while core %0d was stalled", BP_CORE);
            error_count++;
        end
        wait_drain();
        end_test("Back-pressure");

        next_cycle();
        in_iteration_end = '1;
        for (int c = 0; c < CORE_NUM; c++) begin
            in_iteration_id[c] = iteration_t'(8'h40 + c);
        end
        wait_cnt = 0;
        while (iteration_end != '1) begin
            next_cycle();
            wait_cnt++;
            if (iteration_end != '0 && wait_cnt < WAIT_END_DELAY + 1) begin
                $display("iteration_end rose only %0d cycles after the request", wait_cnt);
                error_count++;
            end
        end
        for (int c = 0; c < CORE_NUM; c++) begin
            if (iteration_id[c] !== iteration_t'(8'h40 + c)) begin
                $display("[ERROR] iteration_id[%0d]: expected 0x%h, got 0x%h",
                    c, iteration_t'(8'h40 + c), iteration_id[c]);
                error_count++;
            end
        end
        // A new update ends the quiet period
        next_cycle();
        push_update(0, 3);
        dropped = 1'b0;
        wait_cnt = 0;
        while (!dropped && wait_cnt < 4) begin
            next_cycle();
            wait_cnt++;
            dropped = !iteration_end[0];
        end
        if (!dropped) begin
            $display("iteration_end stayed high on core 0 after an update was sent");
            error_count++;
        end
        in_iteration_end = '0;
        wait_drain();
        end_test("Iteration end");

        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: source/hyperx_network.sv
`timescale 1ns/1ns

module hyperx_network (
    input  logic                                              clk,
    input  logic                                              rst,
    input  hyperx_pkg::core_vec_t                             in_valid,
    input  hyperx_pkg::v_id_t      [hyperx_pkg::CORE_NUM-1:0] in_v_id,
    input  hyperx_pkg::v_value_t   [hyperx_pkg::CORE_NUM-1:0] in_v_value,
    input  hyperx_pkg::core_vec_t                             in_iteration_end,
    input  hyperx_pkg::iteration_t [hyperx_pkg::CORE_NUM-1:0] in_iteration_id,
    input  hyperx_pkg::core_vec_t                             core_full,
    output hyperx_pkg::core_vec_t                             stage_full,
    output hyperx_pkg::core_vec_t                             out_valid,
    output hyperx_pkg::v_id_t      [hyperx_pkg::CORE_NUM-1:0] out_v_id,
    output hyperx_pkg::v_value_t   [hyperx_pkg::CORE_NUM-1:0] out_v_value,
    output hyperx_pkg::core_vec_t                             iteration_end,
    output hyperx_pkg::iteration_t [hyperx_pkg::CORE_NUM-1:0] iteration_id
);
    import hyperx_pkg::*;

    // Column hop: input heads in, vertical buffer writes out
    core_vec_t                 in_hd_valid;
    v_id_t    [CORE_NUM-1:0]   in_hd_v_id;
    v_value_t [CORE_NUM-1:0]   in_hd_v_value;
    core_vec_t                 ver_full;
    core_vec_t                 ver_pop;
    core_vec_t                 ver_dl_valid;
    v_id_t    [CORE_NUM-1:0]   ver_dl_v_id;
    v_value_t [CORE_NUM-1:0]   ver_dl_v_value;

    // Row hop: vertical heads in, horizontal buffer writes out
    core_vec_t                 ver_hd_valid;
    v_id_t    [CORE_NUM-1:0]   ver_hd_v_id;
    v_value_t [CORE_NUM-1:0]   ver_hd_v_value;
    core_vec_t                 hor_full;
    core_vec_t                 hor_pop;
    core_vec_t                 hor_dl_valid;
    v_id_t    [CORE_NUM-1:0]   hor_dl_v_id;
    v_value_t [CORE_NUM-1:0]   hor_dl_v_value;

    ////////////////////////////////////////////////////////////////////////////
    // Nodes, core n sits at x = n % COL_NUM, y = n / COL_NUM
    ////////////////////////////////////////////////////////////////////////////

    for (genvar n = 0; n < CORE_NUM; n++) begin : g_node
        router_node u_node (
            .clk              (clk),
            .rst              (rst),
            .in_valid         (in_valid[n]),
            .in_v_id          (in_v_id[n]),
            .in_v_value       (in_v_value[n]),
            .in_iteration_end (in_iteration_end[n]),
            .in_iteration_id  (in_iteration_id[n]),
            .core_full        (core_full[n]),
            .ver_pop          (ver_pop[n]),
            .ver_dl_valid     (ver_dl_valid[n]),
            .ver_dl_v_id      (ver_dl_v_id[n]),
            .ver_dl_v_value   (ver_dl_v_value[n]),
            .hor_pop          (hor_pop[n]),
            .hor_dl_valid     (hor_dl_valid[n]),
            .hor_dl_v_id      (hor_dl_v_id[n]),
            .hor_dl_v_value   (hor_dl_v_value[n]),
            .stage_full       (stage_full[n]),
            .in_hd_valid      (in_hd_valid[n]),
            .in_hd_v_id       (in_hd_v_id[n]),
            .in_hd_v_value    (in_hd_v_value[n]),
            .ver_full         (ver_full[n]),
            .ver_hd_valid     (ver_hd_valid[n]),
            .ver_hd_v_id      (ver_hd_v_id[n]),
            .ver_hd_v_value   (ver_hd_v_value[n]),
            .hor_full         (hor_full[n]),
            .out_valid        (out_valid[n]),
            .out_v_id         (out_v_id[n]),
            .out_v_value      (out_v_value[n]),
            .iteration_end    (iteration_end[n]),
            .iteration_id     (iteration_id[n])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Column switches, decode the row bit
    ////////////////////////////////////////////////////////////////////////////

    for (genvar x = 0; x < COL_NUM; x++) begin : g_col
        logic     [ROW_NUM-1:0] hd_valid;
        logic     [ROW_NUM-1:0] dest_full;
        logic     [ROW_NUM-1:0] pop;
        logic     [ROW_NUM-1:0] dl_valid;
        v_id_t    [ROW_NUM-1:0] hd_v_id;
        v_id_t    [ROW_NUM-1:0] dl_v_id;
        v_value_t [ROW_NUM-1:0] hd_v_value;
        v_value_t [ROW_NUM-1:0] dl_v_value;

        // Column members are strided by COL_NUM
        for (genvar y = 0; y < ROW_NUM; y++) begin : g_map
            assign hd_valid[y]   = in_hd_valid[y*COL_NUM+x];
            assign hd_v_id[y]    = in_hd_v_id[y*COL_NUM+x];
            assign hd_v_value[y] = in_hd_v_value[y*COL_NUM+x];
            assign dest_full[y]  = ver_full[y*COL_NUM+x];

            assign ver_pop[y*COL_NUM+x]        = pop[y];
            assign ver_dl_valid[y*COL_NUM+x]   = dl_valid[y];
            assign ver_dl_v_id[y*COL_NUM+x]    = dl_v_id[y];
            assign ver_dl_v_value[y*COL_NUM+x] = dl_v_value[y];
        end

        dimension_switch #(
            .N         (ROW_NUM),
            .FIELD_LSB (COL_ID_WIDTH)
        ) u_col_sw (
            .clk        (clk),
            .rst        (rst),
            .hd_valid   (hd_valid),
            .hd_v_id    (hd_v_id),
            .hd_v_value (hd_v_value),
            .dest_full  (dest_full),
            .pop        (pop),
            .dl_valid   (dl_valid),
            .dl_v_id    (dl_v_id),
            .dl_v_value (dl_v_value)
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Row switches, decode the column bits
    ////////////////////////////////////////////////////////////////////////////

    for (genvar y = 0; y < ROW_NUM; y++) begin : g_row
        dimension_switch #(
            .N         (COL_NUM),
            .FIELD_LSB (0)
        ) u_row_sw (
            .clk        (clk),
            .rst        (rst),
            .hd_valid   (ver_hd_valid[y*COL_NUM +: COL_NUM]),
            .hd_v_id    (ver_hd_v_id[y*COL_NUM +: COL_NUM]),
            .hd_v_value (ver_hd_v_value[y*COL_NUM +: COL_NUM]),
            .dest_full  (hor_full[y*COL_NUM +: COL_NUM]),
            .pop        (hor_pop[y*COL_NUM +: COL_NUM]),
            .dl_valid   (hor_dl_valid[y*COL_NUM +: COL_NUM]),
            .dl_v_id    (hor_dl_v_id[y*COL_NUM +: COL_NUM]),
            .dl_v_value (hor_dl_v_value[y*COL_NUM +: COL_NUM])
        );
    end

endmodule

// File: source/router_node.sv
`timescale 1ns/1ns

module router_node (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  hyperx_pkg::v_id_t      in_v_id,
    input  hyperx_pkg::v_value_t   in_v_value,
    input  logic                   in_iteration_end,
    input  hyperx_pkg::iteration_t in_iteration_id,
    input  logic                   core_full,
    input  logic                   ver_pop,
    input  logic                   ver_dl_valid,
    input  hyperx_pkg::v_id_t      ver_dl_v_id,
    input  hyperx_pkg::v_value_t   ver_dl_v_value,
    input  logic                   hor_pop,
    input  logic                   hor_dl_valid,
    input  hyperx_pkg::v_id_t      hor_dl_v_id,
    input  hyperx_pkg::v_value_t   hor_dl_v_value,
    output logic                   stage_full,
    output logic                   in_hd_valid,
    output hyperx_pkg::v_id_t      in_hd_v_id,
    output hyperx_pkg::v_value_t   in_hd_v_value,
    output logic                   ver_full,
    output logic                   ver_hd_valid,
    output hyperx_pkg::v_id_t      ver_hd_v_id,
    output hyperx_pkg::v_value_t   ver_hd_v_value,
    output logic                   hor_full,
    output logic                   out_valid,
    output hyperx_pkg::v_id_t      out_v_id,
    output hyperx_pkg::v_value_t   out_v_value,
    output logic                   iteration_end,
    output hyperx_pkg::iteration_t iteration_id
);
    import hyperx_pkg::*;

    localparam int UPD_W     = V_ID_WIDTH + V_VALUE_WIDTH;
    localparam int END_CNT_W = $clog2(WAIT_END_DELAY + 1);

    logic [UPD_W-1:0]     in_word;
    logic [UPD_W-1:0]     ver_word;
    logic [UPD_W-1:0]     hor_word;
    logic                 in_empty;
    logic                 ver_empty;
    logic                 hor_empty;
    logic                 deliver;
    logic                 end_cond;
    logic [END_CNT_W-1:0] end_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Buffers: input, after the column hop, after the row hop
    ////////////////////////////////////////////////////////////////////////////

    update_fifo #(.DWIDTH(UPD_W)) u_in_fifo (
        .clk       (clk),
        .rst       (rst),
        .din       ({in_v_id, in_v_value}),
        .wr_en     (in_valid),
        .rd_en     (ver_pop),
        .dout      (in_word),
        .empty     (in_empty),
        .prog_full (stage_full)
    );

    update_fifo #(.DWIDTH(UPD_W)) u_ver_fifo (
        .clk       (clk),
        .rst       (rst),
        .din       ({ver_dl_v_id, ver_dl_v_value}),
        .wr_en     (ver_dl_valid),
        .rd_en     (hor_pop),
        .dout      (ver_word),
        .empty     (ver_empty),
        .prog_full (ver_full)
    );

    update_fifo #(.DWIDTH(UPD_W)) u_hor_fifo (
        .clk       (clk),
        .rst       (rst),
        .din       ({hor_dl_v_id, hor_dl_v_value}),
        .wr_en     (hor_dl_valid),
        .rd_en     (deliver),
        .dout      (hor_word),
        .empty     (hor_empty),
        .prog_full (hor_full)
    );

    assign in_hd_valid = !in_empty;
    assign {in_hd_v_id, in_hd_v_value} = in_word;

    assign ver_hd_valid = !ver_empty;
    assign {ver_hd_v_id, ver_hd_v_value} = ver_word;

    ////////////////////////////////////////////////////////////////////////////
    // Delivery to the owning core
    ////////////////////////////////////////////////////////////////////////////

    assign deliver = !hor_empty && !core_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= deliver;
        end
    end

    always_ff @(posedge clk) begin
        if (deliver) begin
            {out_v_id, out_v_value} <= hor_word;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Iteration end
    ////////////////////////////////////////////////////////////////////////////

    assign end_cond = in_iteration_end && in_empty && ver_empty && hor_empty;

    always_ff @(posedge clk) begin
        iteration_id <= in_iteration_id;
    end

    // Count up while quiet, report once the wait has elapsed
    always_ff @(posedge clk) begin
        if (rst) begin
            end_cnt       <= '0;
            iteration_end <= 1'b0;
        end else if (!end_cond) begin
            end_cnt       <= '0;
            iteration_end <= 1'b0;
        end else if (end_cnt == END_CNT_W'(WAIT_END_DELAY)) begin
            iteration_end <= 1'b1;
        end else begin
            end_cnt       <= end_cnt + 1'b1;
            iteration_end <= 1'b0;
        end
    end

endmodule

// File: source/dimension_switch.sv
`timescale 1ns/1ns

module dimension_switch #(
    parameter int N         = 4,
    parameter int FIELD_LSB = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [N-1:0]                 hd_valid,
    input  hyperx_pkg::v_id_t    [N-1:0] hd_v_id,
    input  hyperx_pkg::v_value_t [N-1:0] hd_v_value,
    input  logic [N-1:0]                 dest_full,
    output logic [N-1:0]                 pop,
    output logic [N-1:0]                 dl_valid,
    output hyperx_pkg::v_id_t    [N-1:0] dl_v_id,
    output hyperx_pkg::v_value_t [N-1:0] dl_v_value
);
    // Coordinate bits decoded by this switch
    localparam int FW = $clog2(N);

    // req[d][s]: source s wants destination d
    logic [N-1:0][N-1:0]  req;
    logic [N-1:0][FW-1:0] grant_id;

    ////////////////////////////////////////////////////////////////////////////
    // One arbiter per destination
    ////////////////////////////////////////////////////////////////////////////

    for (genvar d = 0; d < N; d++) begin : g_dest

        for (genvar s = 0; s < N; s++) begin : g_src
            assign req[d][s] = hd_valid[s]
                && !dest_full[d]
                && (hd_v_id[s][FIELD_LSB +: FW] == FW'(d));
        end

        rotating_arbiter #(
            .N       (N),
            .SELF_ID (d)
        ) u_arb (
            .clk         (clk),
            .rst         (rst),
            .req         (req[d]),
            .grant_valid (dl_valid[d]),
            .grant_id    (grant_id[d])
        );

        // Granted head goes straight into the destination buffer
        assign dl_v_id[d]    = hd_v_id[grant_id[d]];
        assign dl_v_value[d] = hd_v_value[grant_id[d]];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pops back to the sources
    ////////////////////////////////////////////////////////////////////////////

    // A head matches a single coordinate, so at most one arbiter takes it
    always_comb begin
        pop = '0;
        for (int d = 0; d < N; d++) begin
            if (dl_valid[d]) begin
                pop[grant_id[d]] = 1'b1;
            end
        end
    end

endmodule

// File: source/rotating_arbiter.sv
`timescale 1ns/1ns

module rotating_arbiter #(
    parameter int N       = 4,
    parameter int SELF_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [N-1:0]         req,
    output logic                 grant_valid,
    output logic [$clog2(N)-1:0] grant_id
);
    localparam int ID_W = $clog2(N);

    logic [N-1:0]   ptr;
    logic [2*N-1:0] req_dbl;
    logic [2*N-1:0] grant_dbl;
    logic [N-1:0]   grant;

    ////////////////////////////////////////////////////////////////////////////
    // Priority pointer
    ////////////////////////////////////////////////////////////////////////////

    // One-hot, moves up one slot every cycle whether or not anyone was granted
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= N'(1) << SELF_ID;
        end else begin
            ptr <= {ptr[N-2:0], ptr[N-1]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Grant selection
    ////////////////////////////////////////////////////////////////////////////

    // Doubling the request vector lets the borrow wrap past the top
    assign req_dbl   = {req, req};
    assign grant_dbl = req_dbl & ~(req_dbl - {{N{1'b0}}, ptr});

    // First requester at or after ptr, folded back to N bits
    assign grant = grant_dbl[N-1:0] | grant_dbl[2*N-1:N];

    assign grant_valid = |req;

    // One-hot to index
    always_comb begin
        grant_id = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (grant[i]) begin
                grant_id = ID_W'(i);
            end
        end
    end

endmodule

// File: source/update_fifo.sv
`timescale 1ns/1ns

module update_fifo #(
    parameter int DWIDTH = 48
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [DWIDTH-1:0] din,
    input  logic              wr_en,
    input  logic              rd_en,
    output logic [DWIDTH-1:0] dout,
    output logic              empty,
    output logic              prog_full
);
    import hyperx_pkg::*;

    localparam int DEPTH = 1 << FIFO_AWIDTH;

    logic [DWIDTH-1:0]      mem [DEPTH];
    logic [FIFO_AWIDTH-1:0] wr_ptr;
    logic [FIFO_AWIDTH-1:0] rd_ptr;
    logic [FIFO_AWIDTH:0]   count;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    assign full  = (count == (FIFO_AWIDTH + 1)'(DEPTH));
    assign empty = (count == '0);
    assign prog_full = (count >= (FIFO_AWIDTH + 1)'(FIFO_PROG_FULL));

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head is always visible, pop just moves the read pointer
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/hyperx_pkg.sv
package hyperx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Grid geometry
    ////////////////////////////////////////////////////////////////////////////

    // Column (x) sits in the id's low bits, row (y) right above it
    localparam int COL_ID_WIDTH = 2;
    localparam int ROW_ID_WIDTH = 1;

    localparam int COL_NUM  = 1 << COL_ID_WIDTH;
    localparam int ROW_NUM  = 1 << ROW_ID_WIDTH;
    localparam int CORE_NUM = ROW_NUM * COL_NUM;

    ////////////////////////////////////////////////////////////////////////////
    // Update format
    ////////////////////////////////////////////////////////////////////////////

    localparam int V_ID_WIDTH      = 16;
    localparam int V_VALUE_WIDTH   = 32;
    localparam int ITERATION_WIDTH = 8;

    // Buffers in every node
    localparam int FIFO_AWIDTH    = 4;
    localparam int FIFO_PROG_FULL = 12;

    // Cycles the end request must hold with empty buffers
    localparam int WAIT_END_DELAY = 20;

    typedef logic [V_ID_WIDTH-1:0]      v_id_t;
    typedef logic [V_VALUE_WIDTH-1:0]   v_value_t;
    typedef logic [ITERATION_WIDTH-1:0] iteration_t;
    typedef logic [CORE_NUM-1:0]        core_vec_t;

endpackage
